// File: memSubsystem.f
source/busPkg.sv
source/pipePkg.sv
source/storeFormatter.sv
source/loadExtractor.sv
source/memStage.sv
source/dataRam.sv
source/memSubsystem.sv
testbench/memSubsystemTb.sv

// File: source/busPkg.sv
package busPkg;

    // Only the double has no unsigned form
    typedef enum logic [2:0] {
        ModeByte   = 3'd0,
        ModeByteU  = 3'd1,
        ModeHalf   = 3'd2,
        ModeHalfU  = 3'd3,
        ModeWord   = 3'd4,
        ModeWordU  = 3'd5,
        ModeDouble = 3'd6
    } MemMode;

    // Encoded as log2 of the byte count
    typedef enum logic [2:0] {
        SizeByte   = 3'd0,
        SizeHalf   = 3'd1,
        SizeWord   = 3'd2,
        SizeDouble = 3'd3
    } MemSize;

    typedef logic [7:0] Strobe;

    typedef union packed {
        logic [63:0]      raw;
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
    } DataLanes;

    typedef struct packed {
        logic        valid;
        logic [63:0] addr;
        MemSize      size;
        Strobe       strobe;
        DataLanes    data;
    } DbusReq;

    typedef struct packed {
        logic     addrOk;
        logic     dataOk;
        DataLanes data;
    } DbusResp;

    localparam int BusOffsetBits = 3;
    localparam int RamDepthWords = 256;
    localparam int RamIndexBits = $clog2(RamDepthWords);
    localparam int RamWaitCycles = 2;
    localparam int RamWaitBits = $clog2(RamWaitCycles + 1);

endpackage

// File: source/dataRam.sv
module dataRam (
    input  logic            clk,
    input  logic            rst,
    input  busPkg::DbusReq  dbusReq,
    output busPkg::DbusResp dbusResp
);
    import busPkg::*;

    DataLanes                mem [RamDepthWords];
    logic [RamWaitBits-1:0]  waitCount;
    logic [RamIndexBits-1:0] index;
    logic                    respond;

    assign index = dbusReq.addr[BusOffsetBits +: RamIndexBits];

    // Both strobes fire once the request has waited its fixed number of cycles
    assign respond = dbusReq.valid && (waitCount == RamWaitBits'(RamWaitCycles));

    assign dbusResp.addrOk = respond;
    assign dbusResp.dataOk = respond;
    assign dbusResp.data = mem[index];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            waitCount <= '0;
        end else if (!dbusReq.valid || respond) begin
            waitCount <= '0;
        end else begin
            waitCount <= waitCount + 1'b1;
        end
    end

    // Loads carry a zero strobe, so only stores change the array
    always_ff @(posedge clk) begin
        if (respond) begin
            for (int i = 0; i < 8; i++) begin
                if (dbusReq.strobe[i]) begin
                    mem[index].bytes[i] <= dbusReq.data.bytes[i];
                end
            end
        end
    end

endmodule

// File: source/loadExtractor.sv
module loadExtractor (
    input  logic [63:0]      address,
    input  busPkg::DataLanes busData,
    input  busPkg::MemMode   memMode,
    output logic [63:0]      loadData
);
    import busPkg::*;

    logic [BusOffsetBits-1:0] offset;
    logic [7:0]               byteLane;
    logic [15:0]              halfLane;
    logic [31:0]              wordLane;

    assign offset = address[BusOffsetBits-1:0];

    // Addresses are size aligned, so the upper offset bits select the lane
    assign byteLane = busData.bytes[offset];
    assign halfLane = busData.halves[offset[2:1]];
    assign wordLane = busData.words[offset[2]];

    always_comb begin
        case (memMode)
            ModeByte: begin
                loadData = {{56{byteLane[7]}}, byteLane};
            end
            ModeByteU: begin
                loadData = {56'd0, byteLane};
            end
            ModeHalf: begin
                loadData = {{48{halfLane[15]}}, halfLane};
            end
            ModeHalfU: begin
                loadData = {48'd0, halfLane};
            end
            ModeWord: begin
                loadData = {{32{wordLane[31]}}, wordLane};
            end
            ModeWordU: begin
                loadData = {32'd0, wordLane};
            end
            default: begin
                loadData = busData.raw;
            end
        endcase
    end

endmodule

// File: source/memStage.sv
module memStage (
    input  logic                  clk,
    input  logic                  rst,
    input  pipePkg::ExMemReg      stageIn,
    input  logic                  advance,
    output pipePkg::MemWbReg      stageOut,
    output pipePkg::ForwardSource forward,
    output logic                  okToProceed,
    output busPkg::DbusReq        dbusReq,
    input  busPkg::DbusResp       dbusResp
);
    import busPkg::*;

    logic        started;
    logic        done;
    logic        memOp;
    logic        respSeen;
    DataLanes    respData;
    logic [63:0] fmtAddr;
    MemSize      fmtSize;
    Strobe       fmtStrobe;
    DataLanes    fmtData;
    logic [63:0] loadData;

    storeFormatter storeFormatter_i (
        .address   (stageIn.aluOut),
        .storeData (stageIn.rs2),
        .memMode   (stageIn.memMode),
        .busAddr   (fmtAddr),
        .size      (fmtSize),
        .strobe    (fmtStrobe),
        .busData   (fmtData)
    );

    loadExtractor loadExtractor_i (
        .address  (stageIn.aluOut),
        .busData  (respData),
        .memMode  (stageIn.memMode),
        .loadData (loadData)
    );

    assign memOp = stageIn.valid && (stageIn.isMemRead || stageIn.isMemWrite);
    assign respSeen = started && dbusReq.valid && dbusResp.addrOk && dbusResp.dataOk;

    // A memory instruction holds the pipeline until its response has been captured
    assign okToProceed = !memOp || done;

    assign forward.valid = stageIn.valid && (stageIn.wd != 5'd0);
    assign forward.isWb = stageIn.isWriteBack;
    assign forward.wd = stageIn.wd;
    assign forward.wdData = stageIn.isMemRead ? loadData : stageIn.aluOut;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stageOut <= '0;
            dbusReq <= '0;
            started <= 1'b0;
            done <= 1'b0;
        end else begin
            if (advance) begin
                stageOut <= '{
                    valid:         stageIn.valid,
                    instrAddr:     stageIn.instrAddr,
                    instr:         stageIn.instr,
                    aluOut:        stageIn.aluOut,
                    memOut:        loadData,
                    wd:            stageIn.wd,
                    isWriteBack:   stageIn.isWriteBack,
                    isMemRead:     stageIn.isMemRead,
                    isBranch:      stageIn.isBranch,
                    isJump:        stageIn.isJump,
                    branchAdopted: stageIn.flagResult
                };
                started <= 1'b0;
                done <= 1'b0;
            end
            if (respSeen) begin
                done <= 1'b1;
                dbusReq.valid <= 1'b0;
            end
            // One request per instruction; started stays set until the next advance
            if (memOp && !started) begin
                started <= 1'b1;
                dbusReq.valid <= 1'b1;
                dbusReq.addr <= fmtAddr;
                dbusReq.size <= fmtSize;
                dbusReq.strobe <= stageIn.isMemWrite ? fmtStrobe : '0;
                dbusReq.data <= fmtData;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (respSeen) begin
            respData <= dbusResp.data;
        end
    end

endmodule

// File: source/memSubsystem.sv
module memSubsystem (
    input  logic                  clk,
    input  logic                  rst,
    input  pipePkg::ExMemReg      stageIn,
    input  logic                  advance,
    output pipePkg::MemWbReg      stageOut,
    output pipePkg::ForwardSource forward,
    output logic                  okToProceed
);
    import busPkg::*;

    DbusReq  dbusReq;
    DbusResp dbusResp;

    memStage memStage_i (
        .clk         (clk),
        .rst         (rst),
        .stageIn     (stageIn),
        .advance     (advance),
        .stageOut    (stageOut),
        .forward     (forward),
        .okToProceed (okToProceed),
        .dbusReq     (dbusReq),
        .dbusResp    (dbusResp)
    );

    dataRam dataRam_i (
        .clk      (clk),
        .rst      (rst),
        .dbusReq  (dbusReq),
        .dbusResp (dbusResp)
    );

endmodule

// File: source/pipePkg.sv
package pipePkg;

    typedef struct packed {
        logic           valid;
        logic [63:0]    instrAddr;
        logic [31:0]    instr;
        logic [63:0]    aluOut;
        logic [63:0]    rs2;
        logic [4:0]     wd;
        logic           isWriteBack;
        logic           isMemRead;
        logic           isMemWrite;
        busPkg::MemMode memMode;
        logic           isBranch;
        logic           isJump;
        logic           flagResult;
    } ExMemReg;

    typedef struct packed {
        logic        valid;
        logic [63:0] instrAddr;
        logic [31:0] instr;
        logic [63:0] aluOut;
        logic [63:0] memOut;
        logic [4:0]  wd;
        logic        isWriteBack;
        logic        isMemRead;
        logic        isBranch;
        logic        isJump;
        logic        branchAdopted;
    } MemWbReg;

    // Consumed by the forwarding muxes of earlier stages
    typedef struct packed {
        logic        valid;
        logic        isWb;
        logic [4:0]  wd;
        logic [63:0] wdData;
    } ForwardSource;

endpackage

// File: source/storeFormatter.sv
module storeFormatter (
    input  logic [63:0]      address,
    input  logic [63:0]      storeData,
    input  busPkg::MemMode   memMode,
    output logic [63:0]      busAddr,
    output busPkg::MemSize   size,
    output busPkg::Strobe    strobe,
    output busPkg::DataLanes busData
);
    import busPkg::*;

    logic [BusOffsetBits-1:0] offset;

    assign offset = address[BusOffsetBits-1:0];

    // The slave sees whole bus words and picks bytes by strobe
    assign busAddr = {address[63:BusOffsetBits], {BusOffsetBits{1'b0}}};

    always_comb begin
        busData.raw = '0;
        strobe = '0;
        case (memMode)
            ModeByte, ModeByteU: begin
                size = SizeByte;
                busData.bytes[offset] = storeData[7:0];
                strobe[offset] = 1'b1;
            end
            ModeHalf, ModeHalfU: begin
                size = SizeHalf;
                busData.halves[offset[2:1]] = storeData[15:0];
                strobe = 8'h03 << {offset[2:1], 1'b0};
            end
            ModeWord, ModeWordU: begin
                size = SizeWord;
                busData.words[offset[2]] = storeData[31:0];
                strobe = 8'h0f << {offset[2], 2'b00};
            end
            default: begin
                size = SizeDouble;
                busData.raw = storeData;
                strobe = '1;
            end
        endcase
    end

endmodule

// File: testbench/memSubsystemTb.sv
module memSubsystemTb;
    timeunit 1ns;
    timeprecision 1ps;
    import busPkg::*;
    import pipePkg::*;

    localparam int RandomCount = 300;
    localparam int InstrTotal = 8 + 16 + 14 + RandomCount;
    localparam int CycleLimit = InstrTotal * (RamWaitCycles + 6) * 2;
    localparam logic [63:0] BaseAddr = 64'h1000;

    logic         clk;
    logic         rst;
    ExMemReg      stageIn;
    logic         advance;
    MemWbReg      stageOut;
    ForwardSource forward;
    logic         okToProceed;

    logic [7:0]   modelMem [RamDepthWords * 8];
    logic [63:0]  randState;
    int           errors;
    int           checks;
    int           cycleCount;

    memSubsystem memSubsystem_i (
        .clk         (clk),
        .rst         (rst),
        .stageIn     (stageIn),
        .advance     (advance),
        .stageOut    (stageOut),
        .forward     (forward),
        .okToProceed (okToProceed)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        randState = randState * 64'd6364136223846793005 + 64'd1442695040888963407;
        return randState[63:32];
    endfunction

    function automatic int accessBytes(MemMode mode);
        case (mode)
            ModeByte, ModeByteU: return 1;
            ModeHalf, ModeHalfU: return 2;
            ModeWord, ModeWordU: return 4;
            default: return 8;
        endcase
    endfunction

    // Gathers the little-endian bytes and extends them by the mode's signedness
    function automatic logic [63:0] modelLoad(logic [63:0] addr, MemMode mode);
        logic [63:0] value;
        int n;
        bit isUnsigned;
        value = '0;
        n = accessBytes(mode);
        isUnsigned = (mode == ModeByteU) || (mode == ModeHalfU) || (mode == ModeWordU);
        for (int i = 0; i < n; i++) begin
            value[8*i +: 8] = modelMem[addr[10:0] + i];
        end
        if (!isUnsigned && n < 8 && value[8*n-1]) begin
            for (int i = 8 * n; i < 64; i++) begin
                value[i] = 1'b1;
            end
        end
        return value;
    endfunction

    function automatic void modelStore(logic [63:0] addr, logic [63:0] data, MemMode mode);
        int n;
        n = accessBytes(mode);
        for (int i = 0; i < n; i++) begin
            modelMem[addr[10:0] + i] = data[8*i +: 8];
        end
    endfunction

    // Kind 0 is an ALU operation, 1 a load and 2 a store
    function automatic ExMemReg makeInstr(int kind, logic [63:0] addr, logic [63:0] data,
                                          MemMode mode);
        ExMemReg instr;
        logic [31:0] flags;
        instr = '0;
        instr.valid = 1'b1;
        instr.instrAddr = {32'd0, nextRand()};
        instr.instr = nextRand();
        instr.aluOut = addr;
        instr.rs2 = data;
        instr.wd = 5'(nextRand());
        instr.isWriteBack = (kind != 2);
        instr.isMemRead = (kind == 1);
        instr.isMemWrite = (kind == 2);
        instr.memMode = mode;
        flags = nextRand();
        instr.isBranch = (kind == 0) && flags[3];
        instr.isJump = (kind == 0) && flags[5];
        instr.flagResult = flags[7];
        return instr;
    endfunction

    task automatic checkValue(logic [63:0] actual, logic [63:0] expected, string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    task automatic runInstr(ExMemReg instr, logic [63:0] expLoad);
        int waitCycles;
        bit going;
        bit isMem;
        MemWbReg held;
        waitCycles = 0;
        going = 0;
        isMem = instr.isMemRead || instr.isMemWrite;
        @(posedge clk);
        stageIn <= instr;
        advance <= 1'b0;
        while (!going) begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles == 1) begin
                held = stageOut;
            end else begin
                checkValue(64'(stageOut !== held), 64'd0, "stageOut changed while stalled");
            end
            if (okToProceed) begin
                if (isMem) begin
                    checkValue(64'(waitCycles >= RamWaitCycles + 1), 64'd1,
                               "okToProceed rose too early");
                end
                checkValue(64'(forward.valid), 64'(instr.wd != 5'd0), "forward.valid");
                checkValue(64'(forward.isWb), 64'(instr.isWriteBack), "forward.isWb");
                checkValue(64'(forward.wd), 64'(instr.wd), "forward.wd");
                checkValue(forward.wdData, instr.isMemRead ? expLoad : instr.aluOut,
                           "forward.wdData");
                if (nextRand() % 4 != 0) begin
                    going = 1;
                end
            end
        end
        @(posedge clk);
        advance <= 1'b1;
        @(posedge clk);
        advance <= 1'b0;
        stageIn <= '0;
        @(negedge clk);
        checkValue(64'(stageOut.valid), 64'd1, "stageOut.valid");
        checkValue(stageOut.aluOut, instr.aluOut, "stageOut.aluOut");
        checkValue(64'(stageOut.wd), 64'(instr.wd), "stageOut.wd");
        checkValue(64'(stageOut.isWriteBack), 64'(instr.isWriteBack), "stageOut.isWriteBack");
        checkValue(64'(stageOut.isMemRead), 64'(instr.isMemRead), "stageOut.isMemRead");
        checkValue(stageOut.instrAddr, instr.instrAddr, "stageOut.instrAddr");
        checkValue(64'(stageOut.instr), 64'(instr.instr), "stageOut.instr");
        checkValue(64'(stageOut.isBranch), 64'(instr.isBranch), "stageOut.isBranch");
        checkValue(64'(stageOut.isJump), 64'(instr.isJump), "stageOut.isJump");
        checkValue(64'(stageOut.branchAdopted), 64'(instr.flagResult), "branchAdopted");
        if (instr.isMemRead) begin
            checkValue(stageOut.memOut, expLoad, "stageOut.memOut");
        end
    endtask

    task automatic doLoad(logic [63:0] addr, MemMode mode);
        runInstr(makeInstr(1, addr, 64'(nextRand()), mode), modelLoad(addr, mode));
    endtask

    task automatic doStore(logic [63:0] addr, logic [63:0] data, MemMode mode);
        runInstr(makeInstr(2, addr, data, mode), 64'd0);
        modelStore(addr, data, mode);
    endtask

    initial begin
        int errBefore;
        int kind;
        int n;
        logic [63:0] addr;
        MemMode mode;
        clk = 1'b0;
        rst = 1'b1;
        stageIn = '0;
        advance = 1'b0;
        randState = 64'd31;
        errors = 0;
        checks = 0;
        cycleCount = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        errBefore = errors;
        @(negedge clk);
        checkValue(64'(stageOut.valid), 64'd0, "stageOut.valid after reset");
        checkValue(64'(okToProceed), 64'd1, "okToProceed after reset");
        $display("Test reset finished with %0d errors", errors - errBefore);

        errBefore = errors;
        for (int i = 0; i < 8; i++) begin
            runInstr(makeInstr(0, {nextRand(), nextRand()}, 64'd0, ModeDouble), 64'd0);
        end
        $display("Test pass-through finished with %0d errors", errors - errBefore);

        // Every word the later tests touch is written first
        errBefore = errors;
        for (int w = 0; w < 16; w++) begin
            doStore(BaseAddr + 64'(w * 8), {nextRand(), nextRand()}, ModeDouble);
        end
        for (int m = 0; m < 7; m++) begin
            mode = MemMode'(m);
            addr = BaseAddr + 64'h40 + 64'(accessBytes(mode) == 8 ? 0 : 8 - accessBytes(mode));
            doStore(addr, 64'h8899AABBCCDDEEF0 ^ 64'(m), mode);
            doLoad(addr, mode);
        end
        $display("Test directed store and load finished with %0d errors", errors - errBefore);

        errBefore = errors;
        for (int i = 0; i < RandomCount; i++) begin
            kind = nextRand() % 3;
            mode = MemMode'(nextRand() % 7);
            n = accessBytes(mode);
            addr = BaseAddr + 64'((nextRand() % 16) * 8) + 64'((nextRand() % 8) & ~(n - 1));
            if (kind == 0) begin
                runInstr(makeInstr(0, {nextRand(), nextRand()}, 64'd0, mode), 64'd0);
            end else if (kind == 1) begin
                doLoad(addr, mode);
            end else begin
                doStore(addr, {nextRand(), nextRand()}, mode);
            end
        end
        $display("Test random mix finished with %0d errors", errors - errBefore);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
